// ==== heapMemory.f ====
hw/heapPkg.sv
hw/heapAllocator.sv
hw/arrayStore.sv
hw/arraySearch.sv
hw/heapController.sv
hw/heapMemory.sv
testbench/heapMemory_assert.sv
testbench/heapMemoryTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the heap memory testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module heapMemoryTb \
  -f heapMemory.f -Mdir obj_dir -o heapMemorySim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/heapMemorySim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== testbench/heapMemoryTb.sv ====
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Heap memory testbench: clock, reset, xorshift data, req/ack driver,
// behavioral model of arrays, sizes and free stack, value checks
//----------------------------------------------------------------------
module heapMemoryTb;

  localparam int arrayBits  = heapPkg::defaultArrayBits;
  localparam int indexBits  = heapPkg::defaultIndexBits;
  localparam int dataBits   = heapPkg::defaultDataBits;
  localparam int arrays     = 2**arrayBits;
  localparam int slots      = 2**indexBits;
  localparam int dataMask   = 2**dataBits - 1;
  localparam int ackTimeout = slots + 20;            // Longest command plus margin

  logic                 clock, resetN, req, ack;
  heapPkg::heapOpcode   opcode;
  logic [arrayBits-1:0] array;
  logic [indexBits-1:0] index;
  logic [dataBits-1:0]  dataIn, dataOut;
  heapPkg::heapError    error;

  // Model state
  int          elements [arrays][slots];
  int          sizes [arrays];
  bit          allocated [arrays];
  int          freeStack [$];                        // Last freed on the back
  int          freshCount;
  logic [31:0] rngState = 32'h5677_2f98;

  heapMemory dut (
    .clock, .resetN, .req, .opcode, .array, .index, .dataIn, .ack, .dataOut, .error
  );

  bind heapMemory heapMemory_assert #(.dataBits(dataBits)) handshakeChecks (
    .clock, .resetN, .req, .ack, .dataOut, .error
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;                       // 8 ns period
  end

  task automatic stopOnFailure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic nextRandom(input int mask, output int value);
    rngState = xorshift(rngState);
    value    = int'(rngState) & mask;
  endtask

  task automatic expectValue(input string signal, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("CHECK FAILED at %0t ns: %s expected %0h, actual %0h",
               $time, signal, expected, actual);
      stopOnFailure("Response mismatch");
    end
  endtask

  //--------------------------------------------------------------------
  // Reference model, updates state and predicts the response
  //--------------------------------------------------------------------
  task automatic predictResult(input heapPkg::heapOpcode op, input int arr, input int idx,
                               input int data, output int expData,
                               output heapPkg::heapError expError);
    int old;
    int next;
    int count;
    expData  = 0;
    expError = heapPkg::none;
    old      = elements[arr][idx];
    if (op == heapPkg::alloc) begin
      if (freeStack.size() == 0 && freshCount == arrays) begin
        expError = heapPkg::outOfMemory;
      end else begin
        if (freeStack.size() != 0)
          expData = freeStack.pop_back();            // Reuse last freed
        else
          expData = freshCount++;
        allocated[expData] = 1'b1;
      end
    end else if (!allocated[arr]) begin
      expError = heapPkg::notAllocated;
    end else begin
      case (op)
        heapPkg::free: begin
          allocated[arr] = 1'b0;
          sizes[arr]     = 0;                        // Freed array comes back empty
          freeStack.push_back(arr);
        end
        heapPkg::write: begin
          elements[arr][idx] = data;
          if (idx >= sizes[arr])
            sizes[arr] = idx + 1;
          expData = data;
        end
        heapPkg::read: begin
          if (idx >= sizes[arr])
            expError = heapPkg::outOfBounds;
          else
            expData = old;
        end
        heapPkg::size: expData = sizes[arr];
        heapPkg::push: begin
          if (sizes[arr] == slots) begin
            expError = heapPkg::arrayFull;
          end else begin
            elements[arr][sizes[arr]] = data;
            sizes[arr]++;
            expData = data;
          end
        end
        heapPkg::pop: begin
          if (sizes[arr] == 0) begin
            expError = heapPkg::arrayEmpty;
          end else begin
            sizes[arr]--;
            expData = elements[arr][sizes[arr]];
          end
        end
        heapPkg::index, heapPkg::less, heapPkg::greater: begin
          count = 0;
          for (int i = 0; i < sizes[arr]; i++) begin
            if (op == heapPkg::index && elements[arr][i] == data)
              count = i + 1;                         // 1-based, last match
            if (op == heapPkg::less && elements[arr][i] < data)
              count++;
            if (op == heapPkg::greater && elements[arr][i] > data)
              count++;
          end
          expData = count;
        end
        default: begin                               // Element arithmetic
          if (idx >= sizes[arr]) begin
            expError = heapPkg::outOfBounds;
          end else begin
            case (op)
              heapPkg::add, heapPkg::addAfter:      next = old + data;
              heapPkg::subtract, heapPkg::subAfter: next = old - data;
              heapPkg::orOp:                        next = old | data;
              heapPkg::xorOp:                       next = old ^ data;
              default:                              next = old & data;
            endcase
            next               = next & dataMask;    // Wraps at dataBits
            elements[arr][idx] = next;
            expData = (op == heapPkg::addAfter || op == heapPkg::subAfter) ? old : next;
          end
        end
      endcase
    end
  endtask

  //--------------------------------------------------------------------
  // One four-phase transaction, entered and left 1 ns after an edge
  //--------------------------------------------------------------------
  task automatic runCommand(input heapPkg::heapOpcode op, input int arr, input int idx,
                            input int data, input int hold = 0);
    int                expData;
    heapPkg::heapError expError;
    int                waited;
    predictResult(op, arr, idx, data, expData, expError);
    opcode = op;
    array  = arrayBits'(arr);
    index  = indexBits'(idx);
    dataIn = dataBits'(data);
    req    = 1'b1;
    waited = 0;
    do begin
      @(posedge clock);
      #1;
      waited++;
      if (waited > ackTimeout)
        stopOnFailure($sformatf("Timeout: no ack for %s", op.name()));
    end while (!ack);
    for (int c = 0; c <= hold; c++) begin           // Slow client keeps req high
      expectValue("dataOut", expData, int'(dataOut));
      expectValue("error", int'(expError), int'(error));
      if (c < hold) begin
        @(posedge clock);
        #1;
      end
    end
    req    = 1'b0;
    waited = 0;
    do begin
      @(posedge clock);
      #1;
      waited++;
      if (waited > ackTimeout)
        stopOnFailure($sformatf("Timeout: ack stuck high after %s", op.name()));
    end while (ack);
  endtask

  always @(posedge clock) begin
    if (dut.handshakeChecks.violations != 0)
      stopOnFailure("A handshake assertion failed");
  end

  initial begin
    heapPkg::heapOpcode searches [3];
    heapPkg::heapOpcode ariths [7];
    int value;
    int slot;
    searches = '{heapPkg::index, heapPkg::less, heapPkg::greater};
    ariths   = '{heapPkg::add, heapPkg::addAfter, heapPkg::subtract, heapPkg::subAfter,
                 heapPkg::orOp, heapPkg::xorOp, heapPkg::andOp};
    freshCount = 0;
    resetN = 1'b0;
    req    = 1'b0;
    opcode = heapPkg::alloc;
    array  = '0;
    index  = '0;
    dataIn = '0;
    repeat (2) @(posedge clock);
    #1 resetN = 1'b1;

    // Allocation order, exhaustion, reuse and double free
    for (int i = 0; i <= arrays; i++)
      runCommand(heapPkg::alloc, 0, 0, 0);          // Last one runs out
    runCommand(heapPkg::free, 1, 0, 0);
    runCommand(heapPkg::free, 3, 0, 0);
    runCommand(heapPkg::alloc, 0, 0, 0);            // Gets 3
    runCommand(heapPkg::alloc, 0, 0, 0);            // Gets 1
    runCommand(heapPkg::free, 2, 0, 0);
    runCommand(heapPkg::free, 2, 0, 0);
    runCommand(heapPkg::read, 2, 0, 0);
    runCommand(heapPkg::alloc, 0, 0, 0);

    // Write grows the size, reads back, bounds
    for (int i = 2; i >= 0; i--) begin
      nextRandom(dataMask, value);
      runCommand(heapPkg::write, 0, i, value);
      runCommand(heapPkg::size, 0, 0, 0);
    end
    for (int i = 0; i < slots; i++)
      runCommand(heapPkg::read, 0, i, 0);           // Slot 3 is out of bounds

    // Stack order, full and empty
    for (int i = 0; i <= slots; i++) begin
      nextRandom(dataMask, value);
      runCommand(heapPkg::push, 1, 0, value);
    end
    for (int i = 0; i <= slots; i++)
      runCommand(heapPkg::pop, 1, 0, 0);
    runCommand(heapPkg::size, 1, 0, 0);

    // Searches on small values so keys repeat, partial then full array
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < (round == 0 ? slots - 1 : 1); i++) begin
        nextRandom(7, value);
        runCommand(heapPkg::push, 2, 0, value);
      end
      foreach (searches[m])
        for (int key = 0; key <= 8; key++)           // 8 never stored
          runCommand(searches[m], 2, 0, key);
    end

    // Element arithmetic, each followed by a read
    for (int i = 0; i < slots; i++) begin
      nextRandom(dataMask, value);
      runCommand(heapPkg::push, 3, 0, value);
    end
    for (int round = 0; round < 3; round++) begin
      foreach (ariths[a]) begin
        nextRandom(slots - 1, slot);
        nextRandom(dataMask, value);
        runCommand(ariths[a], 3, slot, value);
        runCommand(heapPkg::read, 3, slot, 0);
      end
    end
    runCommand(heapPkg::pop, 3, 0, 0);
    runCommand(heapPkg::add, 3, slots - 1, 1);      // Past the new size

    // Slow client holds req
    runCommand(heapPkg::read, 0, 1, 0, 5);
    runCommand(heapPkg::index, 2, 0, 3, 4);
    runCommand(heapPkg::push, 1, 0, 12, 3);

    if (dut.handshakeChecks.violations == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      stopOnFailure("A handshake assertion failed");
    end
  end

endmodule

// ==== testbench/heapMemory_assert.sv ====
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Handshake and reset assertions, bound to the heap memory top level
//----------------------------------------------------------------------
module heapMemory_assert #(
  parameter int dataBits = heapPkg::defaultDataBits
) (
  input logic                clock,
  input logic                resetN,
  input logic                req,
  input logic                ack,
  input logic [dataBits-1:0] dataOut,
  input heapPkg::heapError   error
);

  int unsigned violations = 0;                       // Failed assertions so far

  // Reset behavior
  ackLowInReset: assert property (@(posedge clock) !resetN |-> !ack)
    else begin
      violations++;
      $error("ack high while resetN is low");
    end

  ackLowAfterReset: assert property (@(posedge clock) $rose(resetN) |-> !ack)
    else begin
      violations++;
      $error("ack high on the first edge after reset");
    end

  //--------------------------------------------------------------------
  // Four-phase handshake
  //--------------------------------------------------------------------
  ackNeedsReq: assert property (@(posedge clock) disable iff (!resetN)
      $rose(ack) |-> $past(req))
    else begin
      violations++;
      $error("ack rose without req");
    end

  holdWhileReq: assert property (@(posedge clock) disable iff (!resetN)
      req && ack |=> $stable(ack) && $stable(dataOut) && $stable(error))
    else begin
      violations++;
      $error("Response changed while req and ack were high");
    end

  ackFalls: assert property (@(posedge clock) disable iff (!resetN)
      ack && !req |=> !ack)
    else begin
      violations++;
      $error("ack did not fall one cycle after req went low");
    end

endmodule

// ==== hw/heapMemory.sv ====
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Heap memory top level: controller, allocator, element store and
// search unit
//----------------------------------------------------------------------
module heapMemory #(
  parameter int arrayBits = heapPkg::defaultArrayBits,
  parameter int indexBits = heapPkg::defaultIndexBits,
  parameter int dataBits  = heapPkg::defaultDataBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 req,              // Four-phase request
  input  heapPkg::heapOpcode   opcode,
  input  logic [arrayBits-1:0] array,
  input  logic [indexBits-1:0] index,
  input  logic [dataBits-1:0]  dataIn,
  output logic                 ack,
  output logic [dataBits-1:0]  dataOut,
  output heapPkg::heapError    error
);

  // Allocator links
  logic                 allocate, releaseStrobe, haveFree, isAllocated;
  logic [arrayBits-1:0] releaseArray, freshArray;

  // Store links
  logic [arrayBits-1:0] storeArray, scanArray;
  logic [indexBits-1:0] storeIndex, scanIndex;
  logic                 writeEnable, sizeWrite;
  logic [dataBits-1:0]  writeData, readData, scanData;
  logic [indexBits:0]   newSize, currentSize;

  // Search links
  logic                 searchStart, searchDone;
  heapPkg::heapOpcode   searchMode;
  logic [indexBits:0]   searchResult;

  heapController #(.arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits)) controller (
    .clock, .resetN, .req, .opcode, .array, .index, .dataIn, .ack, .dataOut, .error,
    .allocate, .releaseStrobe, .releaseArray, .freshArray, .haveFree, .isAllocated,
    .storeArray, .storeIndex, .writeEnable, .writeData, .sizeWrite, .newSize,
    .readData, .currentSize,
    .searchStart, .searchMode, .searchDone, .searchResult
  );

  heapAllocator #(.arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits)) allocator (
    .clock, .resetN, .allocate, .releaseStrobe, .releaseArray,
    .queryArray(array), .freshArray, .haveFree, .isAllocated
  );

  arrayStore #(.arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits)) store (
    .clock, .resetN, .storeArray, .storeIndex, .writeEnable, .writeData,
    .sizeWrite, .newSize, .scanArray, .scanIndex,
    .readData, .currentSize, .scanData
  );

  arraySearch #(.arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits)) search (
    .clock, .resetN, .searchStart, .searchArray(array), .searchMode,
    .key(dataIn), .scanData, .currentSize,
    .scanArray, .scanIndex, .searchDone, .searchResult
  );

endmodule

// ==== hw/heapController.sv ====
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Heap controller: req/ack handshake FSM, command decode, legality
// checks, element arithmetic and the result registers
//----------------------------------------------------------------------
module heapController #(
  parameter int arrayBits = heapPkg::defaultArrayBits,
  parameter int indexBits = heapPkg::defaultIndexBits,
  parameter int dataBits  = heapPkg::defaultDataBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 req,
  input  heapPkg::heapOpcode   opcode,
  input  logic [arrayBits-1:0] array,
  input  logic [indexBits-1:0] index,
  input  logic [dataBits-1:0]  dataIn,
  output logic                 ack,
  output logic [dataBits-1:0]  dataOut,
  output heapPkg::heapError    error,
  output logic                 allocate,             // Allocator strobes
  output logic                 releaseStrobe,
  output logic [arrayBits-1:0] releaseArray,
  input  logic [arrayBits-1:0] freshArray,
  input  logic                 haveFree,
  input  logic                 isAllocated,
  output logic [arrayBits-1:0] storeArray,           // Store access
  output logic [indexBits-1:0] storeIndex,
  output logic                 writeEnable,
  output logic [dataBits-1:0]  writeData,
  output logic                 sizeWrite,
  output logic [indexBits:0]   newSize,
  input  logic [dataBits-1:0]  readData,
  input  logic [indexBits:0]   currentSize,
  output logic                 searchStart,          // Search control
  output heapPkg::heapOpcode   searchMode,
  input  logic                 searchDone,
  input  logic [indexBits:0]   searchResult
);

  typedef logic [indexBits:0]  sizeType;             // Element count, 0..slots
  typedef logic [dataBits-1:0] dataWord;

  localparam sizeType fullSize = sizeType'(2**indexBits);

  heapPkg::controllerState state;
  heapPkg::heapError       checkError;               // Legality verdict at decode
  logic                    start;                    // req seen in idle
  logic                    accepted;                 // start with no error
  logic                    isSearch, isArith, inAccess;
  dataWord                 newValue, result;

  assign start      = state == heapPkg::idle && req;
  assign accepted   = start && checkError == heapPkg::none;
  assign inAccess   = state == heapPkg::access;
  assign isSearch   = opcode inside {heapPkg::index, heapPkg::less, heapPkg::greater};
  assign isArith    = opcode inside {heapPkg::add, heapPkg::addAfter, heapPkg::subtract,
                                     heapPkg::subAfter, heapPkg::orOp, heapPkg::xorOp,
                                     heapPkg::andOp};

  // Legality checks, first failure wins
  always_comb begin
    checkError = heapPkg::none;
    if (opcode == heapPkg::alloc) begin
      if (!haveFree)
        checkError = heapPkg::outOfMemory;
    end else if (!isAllocated) begin
      checkError = heapPkg::notAllocated;
    end else if ((opcode == heapPkg::read || isArith) && sizeType'(index) >= currentSize) begin
      checkError = heapPkg::outOfBounds;
    end else if (opcode == heapPkg::push && currentSize == fullSize) begin
      checkError = heapPkg::arrayFull;
    end else if (opcode == heapPkg::pop && currentSize == '0) begin
      checkError = heapPkg::arrayEmpty;
    end
  end

  // Element arithmetic on the registered read
  always_comb begin
    case (opcode)
      heapPkg::add, heapPkg::addAfter:      newValue = readData + dataIn;
      heapPkg::subtract, heapPkg::subAfter: newValue = readData - dataIn;
      heapPkg::orOp:                        newValue = readData | dataIn;
      heapPkg::xorOp:                       newValue = readData ^ dataIn;
      heapPkg::andOp:                       newValue = readData & dataIn;
      default:                              newValue = dataIn;   // write, push
    endcase
  end

  always_comb begin
    case (opcode)
      heapPkg::read, heapPkg::pop,
      heapPkg::addAfter, heapPkg::subAfter: result = readData;   // Old value
      heapPkg::size:                        result = dataWord'(currentSize);
      default:                              result = newValue;
    endcase
  end

  assign allocate      = accepted && opcode == heapPkg::alloc;
  assign releaseStrobe = accepted && opcode == heapPkg::free;
  assign searchStart   = accepted && isSearch;
  assign releaseArray  = array;
  assign storeArray    = array;
  assign searchMode    = opcode;
  assign writeData     = newValue;
  assign writeEnable   = inAccess && (opcode inside {heapPkg::write, heapPkg::push} || isArith);

  // Element address and size update
  always_comb begin
    storeIndex = index;
    sizeWrite  = 1'b0;
    newSize    = '0;
    case (opcode)
      heapPkg::push: begin
        storeIndex = indexBits'(currentSize);                    // Slot past the top
        sizeWrite  = inAccess;
        newSize    = sizeType'(currentSize + 1'b1);
      end
      heapPkg::pop: begin
        storeIndex = indexBits'(currentSize - 1'b1);             // Top element
        sizeWrite  = inAccess;
        newSize    = sizeType'(currentSize - 1'b1);
      end
      heapPkg::write: begin
        sizeWrite  = inAccess && sizeType'(index) >= currentSize;  // Grow only
        newSize    = sizeType'(index) + 1'b1;
      end
      heapPkg::free: begin
        sizeWrite  = releaseStrobe;                              // Freed array is empty
      end
      default: ;
    endcase
  end

  //--------------------------------------------------------------------
  // Handshake FSM
  //--------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state   <= heapPkg::idle;
      ack     <= 1'b0;
      dataOut <= '0;
      error   <= heapPkg::none;
    end else begin
      case (state)
        heapPkg::idle: begin
          if (req) begin
            if (checkError != heapPkg::none || opcode inside {heapPkg::alloc, heapPkg::free}) begin
              ack     <= 1'b1;                                   // Answer at decode
              error   <= checkError;
              dataOut <= allocate ? dataWord'(freshArray) : '0;
              state   <= heapPkg::respond;
            end else if (isSearch) begin
              state   <= heapPkg::scan;
            end else begin
              state   <= heapPkg::access;
            end
          end
        end
        heapPkg::access: begin
          ack     <= 1'b1;                                       // Write lands this edge
          error   <= heapPkg::none;
          dataOut <= result;
          state   <= heapPkg::respond;
        end
        heapPkg::scan: begin
          if (searchDone) begin
            ack     <= 1'b1;
            error   <= heapPkg::none;
            dataOut <= dataWord'(searchResult);
            state   <= heapPkg::respond;
          end
        end
        default: begin                                           // respond
          if (!req) begin
            ack   <= 1'b0;
            state <= heapPkg::idle;
          end
        end
      endcase
    end
  end

endmodule

// ==== hw/arraySearch.sv ====
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Sequential search over one array: last matching position, count
// below key and count above key
//----------------------------------------------------------------------
module arraySearch #(
  parameter int arrayBits = heapPkg::defaultArrayBits,
  parameter int indexBits = heapPkg::defaultIndexBits,
  parameter int dataBits  = heapPkg::defaultDataBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 searchStart,          // One-cycle pulse
  input  logic [arrayBits-1:0] searchArray,
  input  heapPkg::heapOpcode   searchMode,           // index, less or greater
  input  logic [dataBits-1:0]  key,
  input  logic [dataBits-1:0]  scanData,
  input  logic [indexBits:0]   currentSize,
  output logic [arrayBits-1:0] scanArray,            // Store scan address
  output logic [indexBits-1:0] scanIndex,
  output logic                 searchDone,
  output logic [indexBits:0]   searchResult
);

  typedef logic [indexBits-1:0] slotType;
  typedef logic [indexBits:0]   countType;

  localparam slotType lastSlot = slotType'(2**indexBits - 1);

  logic                 running;
  slotType              position;                    // Slot now on scanData
  countType             sizeQ;                       // Size latched at start
  logic [arrayBits-1:0] arrayQ;
  logic                 live, hit;

  // Slot 0 is addressed in the start cycle, so the scan needs no bubble
  assign scanArray = running ? arrayQ : searchArray;
  assign scanIndex = running ? slotType'(position + 1'b1) : '0;
  assign live      = countType'(position) < sizeQ;   // Ignore slots past the size

  always_comb begin
    case (searchMode)
      heapPkg::less:    hit = scanData < key;
      heapPkg::greater: hit = scanData > key;
      default:          hit = scanData == key;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      running      <= 1'b0;
      position     <= '0;
      sizeQ        <= '0;
      arrayQ       <= '0;
      searchDone   <= 1'b0;
      searchResult <= '0;
    end else begin
      searchDone <= 1'b0;
      if (searchStart) begin
        running      <= 1'b1;
        position     <= '0;
        sizeQ        <= currentSize;
        arrayQ       <= searchArray;
        searchResult <= '0;                          // Zero means not found
      end else if (running) begin
        if (live && hit) begin
          if (searchMode == heapPkg::index)
            searchResult <= countType'(position) + 1'b1;   // Last match wins
          else
            searchResult <= searchResult + 1'b1;
        end
        position <= position + 1'b1;
        if (position == lastSlot) begin
          running    <= 1'b0;
          searchDone <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== hw/arrayStore.sv ====
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Element memory with a controller port and a scan port, and the
// per-array size table
//----------------------------------------------------------------------
module arrayStore #(
  parameter int arrayBits = heapPkg::defaultArrayBits,
  parameter int indexBits = heapPkg::defaultIndexBits,
  parameter int dataBits  = heapPkg::defaultDataBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic [arrayBits-1:0] storeArray,           // Controller port
  input  logic [indexBits-1:0] storeIndex,
  input  logic                 writeEnable,
  input  logic [dataBits-1:0]  writeData,
  input  logic                 sizeWrite,
  input  logic [indexBits:0]   newSize,
  input  logic [arrayBits-1:0] scanArray,            // Search port, read only
  input  logic [indexBits-1:0] scanIndex,
  output logic [dataBits-1:0]  readData,
  output logic [indexBits:0]   currentSize,          // Size of storeArray
  output logic [dataBits-1:0]  scanData
);

  typedef logic [arrayBits+indexBits-1:0] wordAddr;  // {array, index}
  typedef logic [dataBits-1:0]            dataWord;
  typedef logic [indexBits:0]             sizeType;

  localparam int arrays = 2**arrayBits;
  localparam int words  = 2**(arrayBits + indexBits);

  dataWord memory [words];                           // Arrays in fixed blocks
  sizeType sizes  [arrays];
  wordAddr storeAddr, scanAddr;

  assign storeAddr   = {storeArray, storeIndex};
  assign scanAddr    = {scanArray, scanIndex};
  assign currentSize = sizes[storeArray];

  // Two registered read ports, one write port
  always_ff @(posedge clock) begin
    if (writeEnable)
      memory[storeAddr] <= writeData;
    readData <= memory[storeAddr];                   // Old data on a same-edge write
    scanData <= memory[scanAddr];
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < arrays; i++)
        sizes[i] <= '0;                              // Every array empty
    end else if (sizeWrite) begin
      sizes[storeArray] <= newSize;
    end
  end

endmodule

// ==== hw/heapAllocator.sv ====
`timescale 1ns/1ps
//----------------------------------------------------------------------
// Array allocator with per-array allocated flags, a stack of freed
// arrays and a counter of arrays never handed out
//----------------------------------------------------------------------
module heapAllocator #(
  parameter int arrayBits = heapPkg::defaultArrayBits,
  parameter int indexBits = heapPkg::defaultIndexBits,
  parameter int dataBits  = heapPkg::defaultDataBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 allocate,             // Take freshArray
  input  logic                 releaseStrobe,        // Return releaseArray
  input  logic [arrayBits-1:0] releaseArray,
  input  logic [arrayBits-1:0] queryArray,
  output logic [arrayBits-1:0] freshArray,           // Next array to hand out
  output logic                 haveFree,
  output logic                 isAllocated
);

  typedef logic [arrayBits-1:0] arrayNum;
  typedef logic [arrayBits:0]   arrayCount;          // 0..arrays

  localparam int arrays = 2**arrayBits;

  arrayNum            freeStack [arrays];            // Freed arrays with the last on top
  arrayCount          stackTop;                      // Entries on the stack
  arrayCount          freshCount;                    // Arrays never allocated so far
  logic [arrays-1:0]  allocated;
  logic               stackEmpty;

  assign stackEmpty  = stackTop == '0;
  assign haveFree    = !stackEmpty || freshCount != arrayCount'(arrays);
  assign freshArray  = stackEmpty ? arrayNum'(freshCount) : freeStack[arrayNum'(stackTop - 1'b1)];
  assign isAllocated = allocated[queryArray];

  always_ff @(posedge clock) begin
    if (releaseStrobe)
      freeStack[arrayNum'(stackTop)] <= releaseArray;   // Room for every array since a double free is rejected
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated  <= '0;
      stackTop   <= '0;
      freshCount <= '0;
    end else if (allocate) begin
      allocated[freshArray] <= 1'b1;
      if (stackEmpty)
        freshCount <= freshCount + 1'b1;             // Fresh array
      else
        stackTop <= stackTop - 1'b1;                 // Reuse last freed
    end else if (releaseStrobe) begin
      allocated[releaseArray] <= 1'b0;
      stackTop <= stackTop + 1'b1;
    end
  end

endmodule

// ==== hw/heapPkg.sv ====
//----------------------------------------------------------------------
// Shared heap definitions: command opcodes, error codes, controller
// states and the default widths of the top level
//----------------------------------------------------------------------
package heapPkg;

  // Default widths, used unless the top level is overridden
  parameter int defaultArrayBits = 2;                // 4 arrays
  parameter int defaultIndexBits = 2;                // 4 elements per array
  parameter int defaultDataBits  = 12;               // Element width

  // Commands accepted over the req/ack handshake
  typedef enum logic [4:0] {
    alloc    = 5'd0,                                 // Allocate an array
    free     = 5'd1,                                 // Free an array for reuse
    write    = 5'd2,                                 // Write element, may grow size
    read     = 5'd3,                                 // Read element
    size     = 5'd4,                                 // Current size
    push     = 5'd5,
    pop      = 5'd6,
    index    = 5'd7,                                 // Last position of a value, 1-based
    less     = 5'd8,                                 // Count of elements below input
    greater  = 5'd9,                                 // Count of elements above input
    add      = 5'd10,                                // Returns new value
    addAfter = 5'd11,                                // Returns old value
    subtract = 5'd12,
    subAfter = 5'd13,
    orOp     = 5'd14,
    xorOp    = 5'd15,
    andOp    = 5'd16
  } heapOpcode;

  typedef enum logic [2:0] {
    none         = 3'd0,
    notAllocated = 3'd1,                             // Never allocated or already freed
    outOfBounds  = 3'd2,                             // Index at or past current size
    arrayFull    = 3'd3,                             // Push to a full array
    arrayEmpty   = 3'd4,                             // Pop from an empty array
    outOfMemory  = 3'd5                              // Every array in use
  } heapError;

  typedef enum logic [1:0] {
    idle,                                            // Waiting for req
    access,                                          // Element read in flight
    scan,                                            // Search running
    respond                                          // ack high, waiting for req low
  } controllerState;

endpackage
